// File: logic/btb_cfg.svh
// branch target buffer configuration
// sizes shared by the resolve stage, the update queue and the table
// every width in the subsystem derives from these three values

`ifndef BTB_CFG_SVH
`define BTB_CFG_SVH

// ============================================================
// address and table geometry
// ============================================================

// one instruction address is a full word
`define BTB_ADDR_W 32

// the table index comes from the low pc bits, 8 bits give 256 entries
`define BTB_IDX_W 8

// ============================================================
// update queue geometry
// ============================================================

// 4 pointer bits give a circular queue of 16 entries
`define BTB_QPTR_W 4

`endif

// File: logic/btbPkg.sv
// branch target buffer types
// vector types for addresses, table indices and queue pointers,
// shared by all blocks of the subsystem

`include "btb_cfg.svh"

package btbPkg;

	// ============================================================
	// address types
	// ============================================================

	// an instruction address
	// used alike for a branch pc, a stored target and a fall-through value
	typedef logic [`BTB_ADDR_W-1:0] pcT;

	// ============================================================
	// table and queue types
	// ============================================================

	// selects one table entry
	// the low pc bits are used directly, the same way the table is addressed
	typedef logic [`BTB_IDX_W-1:0] btbIdxT;

	// head or tail position inside the update queue
	// it wraps naturally at the queue depth
	typedef logic [`BTB_QPTR_W-1:0] qPtrT;

endpackage

// File: logic/btbUpdateIf.sv
// table update channel
// carries one table write per cycle from the update queue to the table
// there is no acknowledge, the table takes every strobed write

`include "btb_cfg.svh"

interface btbUpdateIf ();

	// one-cycle write strobe
	logic wr;
	// branch address, used both for the index and as the stored tag
	logic [`BTB_ADDR_W-1:0] pc;
	// address to store as the predicted target
	logic [`BTB_ADDR_W-1:0] target;
	// becomes the entry's valid bit, so a not-taken write removes the entry
	logic taken;

	// the queue drives the write
	modport source (
		output wr,
		output pc,
		output target,
		output taken
	);

	// the table receives it
	modport sink (
		input wr,
		input pc,
		input target,
		input taken
	);

endinterface

// File: logic/branchResolve.sv
// branch resolve stage
// checks up to three resolved branches per cycle against the next address
// that fetch predicted, and turns each misprediction into a table update

`include "btb_cfg.svh"

module branchResolve (
	input  logic       rclk,
	input  logic       rst,
	input  logic       resStbA,
	input  btbPkg::pcT resPcA,
	input  logic       resTakenA,
	input  btbPkg::pcT resTargetA,
	input  btbPkg::pcT resPredTargetA,
	input  logic       resStbB,
	input  btbPkg::pcT resPcB,
	input  logic       resTakenB,
	input  btbPkg::pcT resTargetB,
	input  btbPkg::pcT resPredTargetB,
	input  logic       resStbC,
	input  btbPkg::pcT resPcC,
	input  logic       resTakenC,
	input  btbPkg::pcT resTargetC,
	input  btbPkg::pcT resPredTargetC,
	output logic       updStbA,
	output btbPkg::pcT updPcA,
	output btbPkg::pcT updTargetA,
	output logic       updTakenA,
	output logic       updStbB,
	output btbPkg::pcT updPcB,
	output btbPkg::pcT updTargetB,
	output logic       updTakenB,
	output logic       updStbC,
	output btbPkg::pcT updPcC,
	output btbPkg::pcT updTargetC,
	output logic       updTakenC
);
	import btbPkg::*;

	localparam int Slots = 3;

	// slot arrays, index 0 is A and index 2 is C
	logic stbIn [Slots];
	pcT   pcIn [Slots];
	logic takenIn [Slots];
	pcT   targetIn [Slots];
	pcT   predIn [Slots];
	pcT   actualNpc [Slots];
	logic mispredict [Slots];
	logic stbR [Slots];
	pcT   pcR [Slots];
	pcT   targetR [Slots];
	logic takenR [Slots];

	assign stbIn = '{resStbA, resStbB, resStbC};
	assign pcIn = '{resPcA, resPcB, resPcC};
	assign takenIn = '{resTakenA, resTakenB, resTakenC};
	assign targetIn = '{resTargetA, resTargetB, resTargetC};
	assign predIn = '{resPredTargetA, resPredTargetB, resPredTargetC};

	// ============================================================
	// misprediction check
	// ============================================================

	// the real next address is the target when taken, otherwise the next word
	// a slot needs an update only when fetch went somewhere else
	always_comb begin
		for (int i = 0; i < Slots; i++) begin
			actualNpc[i] = takenIn[i] ? targetIn[i] : pcIn[i] + pcT'(4);
			mispredict[i] = stbIn[i] && (actualNpc[i] != predIn[i]);
		end
	end

	// strobes are registered so the queue pushes them one edge later
	always_ff @(posedge rclk) begin
		for (int i = 0; i < Slots; i++) begin
			if (rst)
				stbR[i] <= 1'b0;
			else
				stbR[i] <= mispredict[i];
		end
	end

	// payload only moves on a mispredict, the strobe qualifies it
	always_ff @(posedge rclk) begin
		for (int i = 0; i < Slots; i++) begin
			if (mispredict[i]) begin
				pcR[i] <= pcIn[i];
				targetR[i] <= targetIn[i];
				takenR[i] <= takenIn[i];
			end
		end
	end

	assign updStbA = stbR[0];
	assign updPcA = pcR[0];
	assign updTargetA = targetR[0];
	assign updTakenA = takenR[0];
	assign updStbB = stbR[1];
	assign updPcB = pcR[1];
	assign updTargetB = targetR[1];
	assign updTakenB = takenR[1];
	assign updStbC = stbR[2];
	assign updPcC = pcR[2];
	assign updTargetC = targetR[2];
	assign updTakenC = takenR[2];

endmodule

// File: logic/btbUpdateQueue.sv
// branch target buffer update queue
// accepts up to three updates per cycle in slot order A, B, C and
// hands them to the table one per cycle over the update channel
// updates that find the queue full are lost and raise a sticky flag

`include "btb_cfg.svh"

module btbUpdateQueue (
	input  logic       rclk,
	input  logic       rst,
	input  logic       updStbA,
	input  btbPkg::pcT updPcA,
	input  btbPkg::pcT updTargetA,
	input  logic       updTakenA,
	input  logic       updStbB,
	input  btbPkg::pcT updPcB,
	input  btbPkg::pcT updTargetB,
	input  logic       updTakenB,
	input  logic       updStbC,
	input  btbPkg::pcT updPcC,
	input  btbPkg::pcT updTargetC,
	input  logic       updTakenC,
	btbUpdateIf.source upd,
	output logic       queueOverflow
);
	import btbPkg::*;

	localparam int Slots = 3;
	localparam int Depth = 1 << `BTB_QPTR_W;
	localparam int CntW = `BTB_QPTR_W + 1;

	// one extra bit so a full queue is told apart from an empty one
	typedef logic [CntW-1:0] cntT;

	// queue storage
	pcT   qPc [Depth];
	pcT   qTarget [Depth];
	logic qTaken [Depth];

	qPtrT head;
	qPtrT tail;
	cntT  count;

	logic inStb [Slots];
	pcT   inPc [Slots];
	pcT   inTarget [Slots];
	logic inTaken [Slots];
	logic accept [Slots];
	qPtrT slotPtr [Slots];
	logic [1:0] nAccept;
	logic drop;
	logic pop;

	assign inStb = '{updStbA, updStbB, updStbC};
	assign inPc = '{updPcA, updPcB, updPcC};
	assign inTarget = '{updTargetA, updTargetB, updTargetC};
	assign inTaken = '{updTakenA, updTakenB, updTakenC};

	// ============================================================
	// push side
	// ============================================================

	// accepted slots take consecutive tail positions in slot order
	// free space is judged on the count before this cycle's pop
	always_comb begin
		cntT used;
		used = count;
		nAccept = 2'd0;
		drop = 1'b0;
		for (int i = 0; i < Slots; i++) begin
			accept[i] = 1'b0;
			slotPtr[i] = tail + qPtrT'(nAccept);
			if (inStb[i]) begin
				if (used < cntT'(Depth)) begin
					accept[i] = 1'b1;
					used = used + cntT'(1);
					nAccept = nAccept + 2'd1;
				end else begin
					drop = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge rclk) begin
		for (int i = 0; i < Slots; i++) begin
			if (accept[i]) begin
				qPc[slotPtr[i]] <= inPc[i];
				qTarget[slotPtr[i]] <= inTarget[i];
				qTaken[slotPtr[i]] <= inTaken[i];
			end
		end
	end

	// ============================================================
	// pop side and pointers
	// ============================================================

	// the head entry is on the channel whenever anything is queued,
	// and the table writes it at the same edge that advances the head
	assign pop = (count != cntT'(0));

	always_ff @(posedge rclk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			queueOverflow <= 1'b0;
		end else begin
			if (pop)
				head <= head + qPtrT'(1);
			tail <= tail + qPtrT'(nAccept);
			count <= count + cntT'(nAccept) - cntT'(pop);
			// stays set until reset
			if (drop)
				queueOverflow <= 1'b1;
		end
	end

	assign upd.wr = pop;
	assign upd.pc = qPc[head];
	assign upd.target = qTarget[head];
	assign upd.taken = qTaken[head];

endmodule

// File: logic/btbTable.sv
// branch target buffer table
// holds tag, target and valid per entry, takes one write per cycle and
// answers three lookups per cycle with one cycle of latency
// a miss returns the fall-through address that came with the lookup

`include "btb_cfg.svh"

module btbTable (
	input  logic       rclk,
	input  logic       rst,
	btbUpdateIf.sink   upd,
	input  btbPkg::pcT lookPcA,
	input  btbPkg::pcT lookNpcA,
	input  btbPkg::pcT lookPcB,
	input  btbPkg::pcT lookNpcB,
	input  btbPkg::pcT lookPcC,
	input  btbPkg::pcT lookNpcC,
	output logic       lookHitA,
	output btbPkg::pcT lookTgtA,
	output logic       lookHitB,
	output btbPkg::pcT lookTgtB,
	output logic       lookHitC,
	output btbPkg::pcT lookTgtC
);
	import btbPkg::*;

	localparam int Slots = 3;
	localparam int Entries = 1 << `BTB_IDX_W;

	// ============================================================
	// storage
	// ============================================================

	// the tag is the whole pc, so aliasing pcs never hit on each other
	pcT tagMem [Entries];
	pcT tgtMem [Entries];
	logic [Entries-1:0] validMem;

	btbIdxT wrIdx;

	// lookup port arrays with index 0 for A
	pcT     lookPc [Slots];
	pcT     lookNpc [Slots];
	btbIdxT rdIdx [Slots];
	pcT     pcR [Slots];
	pcT     npcR [Slots];
	pcT     tagR [Slots];
	pcT     tgtR [Slots];
	logic   validR [Slots];
	logic   hit [Slots];
	pcT     tgtOut [Slots];

	assign wrIdx = upd.pc[`BTB_IDX_W-1:0];

	// a write stores the full pc as tag along with the target
	always_ff @(posedge rclk) begin
		if (upd.wr) begin
			tagMem[wrIdx] <= upd.pc;
			tgtMem[wrIdx] <= upd.target;
		end
	end

	// a not-taken write clears valid and so removes the entry
	always_ff @(posedge rclk) begin
		if (rst)
			validMem <= '0;
		else if (upd.wr)
			validMem[wrIdx] <= upd.taken;
	end

	// ============================================================
	// lookup ports
	// ============================================================

	assign lookPc = '{lookPcA, lookPcB, lookPcC};
	assign lookNpc = '{lookNpcA, lookNpcB, lookNpcC};

	always_comb begin
		for (int i = 0; i < Slots; i++)
			rdIdx[i] = lookPc[i][`BTB_IDX_W-1:0];
	end

	// the entry is read at the sampling edge itself
	// so a write at that same edge is not yet seen
	always_ff @(posedge rclk) begin
		for (int i = 0; i < Slots; i++) begin
			pcR[i] <= lookPc[i];
			npcR[i] <= lookNpc[i];
			tagR[i] <= tagMem[rdIdx[i]];
			tgtR[i] <= tgtMem[rdIdx[i]];
		end
	end

	// no port hits in the cycle after reset
	always_ff @(posedge rclk) begin
		for (int i = 0; i < Slots; i++) begin
			if (rst)
				validR[i] <= 1'b0;
			else
				validR[i] <= validMem[rdIdx[i]];
		end
	end

	// hit needs a live entry whose full tag matches the sampled pc
	always_comb begin
		for (int i = 0; i < Slots; i++) begin
			hit[i] = validR[i] && (tagR[i] == pcR[i]);
			tgtOut[i] = hit[i] ? tgtR[i] : npcR[i];
		end
	end

	assign lookHitA = hit[0];
	assign lookTgtA = tgtOut[0];
	assign lookHitB = hit[1];
	assign lookTgtB = tgtOut[1];
	assign lookHitC = hit[2];
	assign lookTgtC = tgtOut[2];

endmodule

// File: logic/btbUnit.sv
// branch target buffer subsystem top level
// resolved branches flow through the resolve stage and the update queue
// into the table, and the table serves three fetch lookups per cycle

`include "btb_cfg.svh"

module btbUnit (
	input  logic       rclk,
	input  logic       rst,
	input  logic       resStbA,
	input  btbPkg::pcT resPcA,
	input  logic       resTakenA,
	input  btbPkg::pcT resTargetA,
	input  btbPkg::pcT resPredTargetA,
	input  logic       resStbB,
	input  btbPkg::pcT resPcB,
	input  logic       resTakenB,
	input  btbPkg::pcT resTargetB,
	input  btbPkg::pcT resPredTargetB,
	input  logic       resStbC,
	input  btbPkg::pcT resPcC,
	input  logic       resTakenC,
	input  btbPkg::pcT resTargetC,
	input  btbPkg::pcT resPredTargetC,
	input  btbPkg::pcT lookPcA,
	input  btbPkg::pcT lookNpcA,
	input  btbPkg::pcT lookPcB,
	input  btbPkg::pcT lookNpcB,
	input  btbPkg::pcT lookPcC,
	input  btbPkg::pcT lookNpcC,
	output logic       lookHitA,
	output btbPkg::pcT lookTgtA,
	output logic       lookHitB,
	output btbPkg::pcT lookTgtB,
	output logic       lookHitC,
	output btbPkg::pcT lookTgtC,
	output logic       queueOverflow
);
	import btbPkg::*;

	// ============================================================
	// resolve to queue, one set of signals per slot
	// ============================================================

	logic updStbA;
	pcT   updPcA;
	pcT   updTargetA;
	logic updTakenA;
	logic updStbB;
	pcT   updPcB;
	pcT   updTargetB;
	logic updTakenB;
	logic updStbC;
	pcT   updPcC;
	pcT   updTargetC;
	logic updTakenC;

	// queue to table write channel
	btbUpdateIf updBus ();

	branchResolve resolve0 (
		.rclk,
		.rst,
		.resStbA, .resPcA, .resTakenA, .resTargetA, .resPredTargetA,
		.resStbB, .resPcB, .resTakenB, .resTargetB, .resPredTargetB,
		.resStbC, .resPcC, .resTakenC, .resTargetC, .resPredTargetC,
		.updStbA, .updPcA, .updTargetA, .updTakenA,
		.updStbB, .updPcB, .updTargetB, .updTakenB,
		.updStbC, .updPcC, .updTargetC, .updTakenC
	);

	// funnels up to three updates per cycle down to one table write
	btbUpdateQueue queue0 (
		.rclk,
		.rst,
		.updStbA, .updPcA, .updTargetA, .updTakenA,
		.updStbB, .updPcB, .updTargetB, .updTakenB,
		.updStbC, .updPcC, .updTargetC, .updTakenC,
		.upd           (updBus),
		.queueOverflow
	);

	btbTable table0 (
		.rclk,
		.rst,
		.upd      (updBus),
		.lookPcA, .lookNpcA, .lookHitA, .lookTgtA,
		.lookPcB, .lookNpcB, .lookHitB, .lookTgtB,
		.lookPcC, .lookNpcC, .lookHitC, .lookTgtC
	);

endmodule

// File: dv/btbUnitTb.sv
// branch target buffer testbench
// drives resolve bursts and three-port lookups into the BTB subsystem
// and checks every lookup result against a reference table kept here
// that follows the misprediction update rule

`include "btb_cfg.svh"

module btbUnitTb;
	timeunit 1ns;
	timeprecision 100ps;

	import btbPkg::*;

	localparam int Slots = 3;
	localparam int Entries = 1 << `BTB_IDX_W;
	// the tests take roughly 150 cycles and this leaves a wide margin
	localparam int CycleLimit = 4000;

	logic rclk;
	logic rst;

	// slot arrays with index 0 for port A
	logic resStb [Slots];
	pcT   resPc [Slots];
	logic resTaken [Slots];
	pcT   resTarget [Slots];
	pcT   resPred [Slots];
	pcT   lookPc [Slots];
	pcT   lookNpc [Slots];
	logic lookHit [Slots];
	pcT   lookTgt [Slots];
	logic queueOverflow;

	// reference table indexed like the DUT table
	logic refValid [Entries];
	pcT   refTag [Entries];
	pcT   refTgt [Entries];
	// how many more updates the reference still follows
	int   refBudget;

	// expected results are staged with the lookup and delayed one edge
	logic chkD;
	logic chkQ = 1'b0;
	logic expHitD [Slots];
	logic expHitQ [Slots];
	pcT   expTgtD [Slots];
	pcT   expTgtQ [Slots];
	logic ovfAllowed;
	logic ovfPrev = 1'b0;

	int seed;
	int valueErrors = 0;
	int otherErrors = 0;
	int cycle = 0;

	btbUnit dut0 (
		.rclk           (rclk),
		.rst            (rst),
		.resStbA        (resStb[0]),
		.resPcA         (resPc[0]),
		.resTakenA      (resTaken[0]),
		.resTargetA     (resTarget[0]),
		.resPredTargetA (resPred[0]),
		.resStbB        (resStb[1]),
		.resPcB         (resPc[1]),
		.resTakenB      (resTaken[1]),
		.resTargetB     (resTarget[1]),
		.resPredTargetB (resPred[1]),
		.resStbC        (resStb[2]),
		.resPcC         (resPc[2]),
		.resTakenC      (resTaken[2]),
		.resTargetC     (resTarget[2]),
		.resPredTargetC (resPred[2]),
		.lookPcA        (lookPc[0]),
		.lookNpcA       (lookNpc[0]),
		.lookPcB        (lookPc[1]),
		.lookNpcB       (lookNpc[1]),
		.lookPcC        (lookPc[2]),
		.lookNpcC       (lookNpc[2]),
		.lookHitA       (lookHit[0]),
		.lookTgtA       (lookTgt[0]),
		.lookHitB       (lookHit[1]),
		.lookTgtB       (lookTgt[1]),
		.lookHitC       (lookHit[2]),
		.lookTgtC       (lookTgt[2]),
		.queueOverflow  (queueOverflow)
	);

	initial begin
		rclk = 1'b0;
		forever #10 rclk = ~rclk;
	end

	// ============================================================
	// helpers
	// ============================================================

	function automatic btbIdxT indexOf(input pcT pc);
		return pc[`BTB_IDX_W-1:0];
	endfunction

	function automatic string portName(input int p);
		return (p == 0) ? "A" : ((p == 1) ? "B" : "C");
	endfunction

	// branch addresses of the overflow bursts with one table index each
	function automatic pcT burstPc(input int k);
		return 32'h0000_C000 + pcT'(k << 2);
	endfunction

	task automatic nextCycle();
		@(posedge rclk);
		#2;
	endtask

	task automatic clearResolve();
		for (int i = 0; i < Slots; i++)
			resStb[i] = 1'b0;
	endtask

	// a slot updates only when the real next address differs from the
	// predicted one, and the later slot of a cycle overwrites the earlier
	task automatic stageResolve(input int s, input pcT pc, input logic taken,
		input pcT target, input pcT pred);
		pcT actual;
		btbIdxT idx;
		actual = taken ? target : pc + 32'd4;
		idx = indexOf(pc);
		resStb[s] = 1'b1;
		resPc[s] = pc;
		resTaken[s] = taken;
		resTarget[s] = target;
		resPred[s] = pred;
		if (actual != pred && refBudget > 0) begin
			refBudget--;
			refTag[idx] = pc;
			refTgt[idx] = target;
			refValid[idx] = taken;
		end
	endtask

	task automatic stageLookup(input int s, input pcT pc);
		btbIdxT idx;
		idx = indexOf(pc);
		lookPc[s] = pc;
		lookNpc[s] = $random(seed);
		expHitD[s] = refValid[idx] && (refTag[idx] == pc);
		expTgtD[s] = expHitD[s] ? refTgt[idx] : lookNpc[s];
	endtask

	task automatic lookupCycle(input pcT pa, input pcT pb, input pcT pc);
		nextCycle();
		clearResolve();
		stageLookup(0, pa);
		stageLookup(1, pb);
		stageLookup(2, pc);
		chkD = 1'b1;
	endtask

	task automatic startBurst();
		nextCycle();
		clearResolve();
		chkD = 1'b0;
	endtask

	// lets queued updates drain into the table with checks off
	task automatic settle(input int n);
		repeat (n) begin
			nextCycle();
			clearResolve();
			chkD = 1'b0;
		end
	endtask

	// ============================================================
	// checks
	// ============================================================

	always @(posedge rclk) begin
		chkQ <= chkD;
		ovfPrev <= rst ? 1'b0 : queueOverflow;
		for (int i = 0; i < Slots; i++) begin
			expHitQ[i] <= expHitD[i];
			expTgtQ[i] <= expTgtD[i];
		end
	end

	// the result of the lookup sampled at the previous edge
	for (genvar p = 0; p < Slots; p++) begin : portCheck
		hitCheck: assert property (@(posedge rclk) chkQ |-> lookHit[p] == expHitQ[p])
			else begin
				valueErrors++;
				$display("Error lookHit%s expected 0x%h got 0x%h", portName(p),
					$sampled(expHitQ[p]), $sampled(lookHit[p]));
			end
		tgtCheck: assert property (@(posedge rclk) chkQ |-> lookTgt[p] == expTgtQ[p])
			else begin
				valueErrors++;
				$display("Error lookTgt%s expected 0x%h got 0x%h", portName(p),
					$sampled(expTgtQ[p]), $sampled(lookTgt[p]));
			end
	end

	ovfQuiet: assert property (@(posedge rclk) disable iff (rst)
		!ovfAllowed |-> !queueOverflow)
		else begin
			valueErrors++;
			$display("Error queueOverflow expected 0x0 got 0x%h", $sampled(queueOverflow));
		end

	// sticky until reset
	ovfSticky: assert property (@(posedge rclk) disable iff (rst) ovfPrev |-> queueOverflow)
		else begin
			valueErrors++;
			$display("Error queueOverflow expected 0x1 got 0x%h", $sampled(queueOverflow));
		end

	always @(posedge rclk) begin
		cycle <= cycle + 1;
		if (cycle >= CycleLimit) begin
			otherErrors++;
			$display("timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("errors: value %0d, other %0d", valueErrors, otherErrors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ============================================================
	// stimulus
	// ============================================================

	initial begin
		seed = 32'h35ebd6a7;
		refBudget = 1000;
		rst = 1'b1;
		chkD = 1'b0;
		ovfAllowed = 1'b0;
		for (int i = 0; i < Slots; i++) begin
			resStb[i] = 1'b0;
			resPc[i] = '0;
			resTaken[i] = 1'b0;
			resTarget[i] = '0;
			resPred[i] = '0;
			lookPc[i] = '0;
			lookNpc[i] = '0;
			expHitD[i] = 1'b0;
			expTgtD[i] = '0;
		end
		for (int e = 0; e < Entries; e++) begin
			refValid[e] = 1'b0;
			refTag[e] = '0;
			refTgt[e] = '0;
		end
		repeat (8) @(posedge rclk);
		#2;
		rst = 1'b0;

		// with an empty table every port returns its own fall-through
		repeat (4) lookupCycle(32'h0000_0400, 32'h0000_1010, 32'h0000_2040);

		// taken branch that fetch predicted as fall-through installs an entry
		startBurst();
		stageResolve(0, 32'h0000_0400, 1'b1, 32'h0000_1800, 32'h0000_0404);
		settle(8);
		repeat (2) lookupCycle(32'h0000_0400, 32'h0000_0400, 32'h0000_0400);
		lookupCycle(32'h0000_0500, 32'h0000_0400, 32'h0000_0404);

		// correct predictions leave the table alone even with a new target
		// and a correctly predicted taken branch installs nothing
		startBurst();
		stageResolve(1, 32'h0000_0400, 1'b1, 32'h0000_2000, 32'h0000_2000);
		stageResolve(2, 32'h0000_0524, 1'b1, 32'h0000_3000, 32'h0000_3000);
		settle(8);
		repeat (2) lookupCycle(32'h0000_0400, 32'h0000_0524, 32'h0000_0400);

		// not taken after a taken prediction clears the entry
		startBurst();
		stageResolve(0, 32'h0000_0400, 1'b0, 32'h0000_1800, 32'h0000_1800);
		settle(8);
		repeat (2) lookupCycle(32'h0000_0400, 32'h0000_0400, 32'h0000_0400);

		// three distinct indices in one cycle
		startBurst();
		stageResolve(0, 32'h0000_1010, 1'b1, 32'h0000_5000, 32'h0000_1014);
		stageResolve(1, 32'h0000_1020, 1'b1, 32'h0000_5100, 32'h0000_1024);
		stageResolve(2, 32'h0000_1034, 1'b1, 32'h0000_5200, 32'h0000_1038);
		settle(8);
		lookupCycle(32'h0000_1010, 32'h0000_1020, 32'h0000_1034);
		lookupCycle(32'h0000_1034, 32'h0000_1010, 32'h0000_1020);

		// A and B hit the same index so B is written last and stays
		startBurst();
		stageResolve(0, 32'h0000_2040, 1'b1, 32'h0000_9000, 32'h0000_2044);
		stageResolve(1, 32'h0000_2040, 1'b1, 32'h0000_9100, 32'h0000_9000);
		stageResolve(2, 32'h0000_2080, 1'b1, 32'h0000_9200, 32'h0000_2084);
		settle(8);
		repeat (2) lookupCycle(32'h0000_2040, 32'h0000_2080, 32'h0000_2040);

		// an aliasing pc replaces the older entry at that index
		startBurst();
		stageResolve(0, 32'h0000_3040, 1'b1, 32'h0000_A000, 32'h0000_3044);
		settle(8);
		repeat (2) lookupCycle(32'h0000_2040, 32'h0000_3040, 32'h0000_2080);

		// ten cycles of three mispredictions overfill the 16 entry queue
		// and only the first sixteen updates are followed by the reference
		refBudget = 16;
		for (int b = 0; b < 10; b++) begin
			startBurst();
			// the eighth burst is the first that finds the queue full
			// and it is pushed two edges after staging, as the last burst is staged
			if (b == 9)
				ovfAllowed = 1'b1;
			for (int s = 0; s < Slots; s++) begin
				stageResolve(s, burstPc(3 * b + s), 1'b1,
					32'h0001_0000 + pcT'((3 * b + s) << 4), burstPc(3 * b + s) + 32'd4);
			end
		end
		settle(40);
		overflowSeen: assert (queueOverflow)
			else begin
				valueErrors++;
				$display("Error queueOverflow expected 0x1 got 0x%h", queueOverflow);
			end
		for (int k = 0; k < 16; k++)
			lookupCycle(burstPc(k), burstPc(15 - k), burstPc(k));

		settle(2);
		$display("errors: value %0d, other %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: btbUnit.f
+incdir+logic
logic/btbPkg.sv
logic/btbUpdateIf.sv
logic/branchResolve.sv
logic/btbUpdateQueue.sv
logic/btbTable.sv
logic/btbUnit.sv
dv/btbUnitTb.sv

// File: run.sh
#!/bin/sh
# builds the BTB testbench with Verilator and runs it
# exits non-zero unless the simulation prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f btbUnit.f --top-module btbUnitTb -o btbSim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

out=$(./obj_dir/btbSim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
else
	echo "pass line not found in simulation output"
	exit 1
fi
